// File: rtl/ifetch_settings.svh
`ifndef IFETCH_SETTINGS_SVH
`define IFETCH_SETTINGS_SVH

// pc, bus address and bus data width
`define IFETCH_ADDR_W 32

// 8 lines, direct mapped
`define L1I_INDEX_W 3
`define L1I_LINES 8

// two 32-bit words per line
`define L1I_OFFSET_W 1

// address width minus index, word offset and byte bits
`define L1I_TAG_W 26

// fence.i encoding, invalidates the whole cache on delivery
`define FENCE_I_WORD 32'h0000100f

`endif

// File: rtl/ifetch_pkg.sv
`default_nettype none

`include "ifetch_settings.svh"

package ifetch_pkg;

  // one fetch address, seen either as the raw pc
  // or split into the cache fields
  typedef union packed {
    logic [`IFETCH_ADDR_W-1:0] raw;
    struct packed {
      logic [`L1I_TAG_W-1:0]    tag;
      logic [`L1I_INDEX_W-1:0]  index;
      logic [`L1I_OFFSET_W-1:0] offset;
      // always zero, pc is word aligned
      logic [1:0]               byte_sel;
    } f;
  } l1i_addr_u;

  // fetch controller states
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    LOOKUP  = 2'd1,
    REFILL  = 2'd2,
    DELIVER = 2'd3
  } fetch_state_e;

endpackage

`default_nettype wire

// File: rtl/l1i_ifs.sv
`default_nettype none

`include "ifetch_settings.svh"

// controller <-> array
// hit and word are combinational from lookup_addr
interface l1i_lookup_if;
  ifetch_pkg::l1i_addr_u       lookup_addr;
  // one-cycle strobe, clears all valid bits at the next edge
  logic                        flush_all;
  logic                        hit;
  logic [`IFETCH_ADDR_W-1:0]   word;

  modport ctrl (
    output lookup_addr,
    output flush_all,
    input  hit,
    input  word
  );

  modport array (
    input  lookup_addr,
    input  flush_all,
    output hit,
    output word
  );
endinterface

// refill unit -> array and controller
interface l1i_fill_if;
  // one word per strobe
  logic                        fill_we;
  logic [`L1I_INDEX_W-1:0]     fill_index;
  logic [`L1I_OFFSET_W-1:0]    fill_offset;
  logic [`L1I_TAG_W-1:0]       fill_tag;
  logic [`IFETCH_ADDR_W-1:0]   fill_word;
  // pulses with the offset 1 write
  logic                        line_done;

  modport refill (
    output fill_we,
    output fill_index,
    output fill_offset,
    output fill_tag,
    output fill_word,
    output line_done
  );

  modport array (
    input  fill_we,
    input  fill_index,
    input  fill_offset,
    input  fill_tag,
    input  fill_word
  );

  modport ctrl (
    input  line_done
  );
endinterface

`default_nettype wire

// File: rtl/ifetch_ctrl.sv
`default_nettype none

`include "ifetch_settings.svh"

module ifetch_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  // upstream pc handshake
  input  logic                      req_valid_i,
  input  logic [`IFETCH_ADDR_W-1:0] req_pc_i,
  output logic                      req_ready_o,
  // downstream instruction handshake
  output logic                      inst_valid_o,
  output logic [`IFETCH_ADDR_W-1:0] inst_o,
  output logic [`IFETCH_ADDR_W-1:0] pc_o,
  input  logic                      inst_ready_i,
  // cache lookup and flush
  l1i_lookup_if.ctrl                lookup,
  // refill request
  output logic                      refill_start_o,
  output ifetch_pkg::l1i_addr_u     refill_addr_o,
  // refill completion
  l1i_fill_if.ctrl                  fill
);

  ifetch_pkg::fetch_state_e  state_q;
  // accepted pc, held until delivery completes
  ifetch_pkg::l1i_addr_u     pc_q;
  // hit word captured in LOOKUP
  logic [`IFETCH_ADDR_W-1:0] inst_q;
  logic                      deliver_done;

  // one fetch at a time, upstream only sees ready when idle
  assign req_ready_o  = (state_q == ifetch_pkg::IDLE);
  assign inst_valid_o = (state_q == ifetch_pkg::DELIVER);
  assign inst_o       = inst_q;
  assign pc_o         = pc_q.raw;

  // downstream took the word this cycle
  assign deliver_done = (state_q == ifetch_pkg::DELIVER) && inst_ready_i;

  // cache is always probed with the held pc
  assign lookup.lookup_addr = pc_q;

  // fence.i leaving the unit wipes the cache
  assign lookup.flush_all = deliver_done && (inst_q == `FENCE_I_WORD);

  // miss seen in LOOKUP kicks off the refill
  assign refill_start_o = (state_q == ifetch_pkg::LOOKUP) && !lookup.hit;

  // line base address, word offset and byte bits cleared
  always_comb
  begin
    refill_addr_o            = pc_q;
    refill_addr_o.f.offset   = '0;
    refill_addr_o.f.byte_sel = '0;
  end

  // state sequencing
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= ifetch_pkg::IDLE;
    end
    else
    begin
      case (state_q)
        ifetch_pkg::IDLE:
        begin
          if (req_valid_i)
          begin
            state_q <= ifetch_pkg::LOOKUP;
          end
        end
        ifetch_pkg::LOOKUP:
        begin
          // hit goes straight out, miss waits for the line
          if (lookup.hit)
          begin
            state_q <= ifetch_pkg::DELIVER;
          end
          else
          begin
            state_q <= ifetch_pkg::REFILL;
          end
        end
        ifetch_pkg::REFILL:
        begin
          // re-check once the line is written
          if (fill.line_done)
          begin
            state_q <= ifetch_pkg::LOOKUP;
          end
        end
        ifetch_pkg::DELIVER:
        begin
          // stall here under back-pressure
          if (inst_ready_i)
          begin
            state_q <= ifetch_pkg::IDLE;
          end
        end
        default:
        begin
          state_q <= ifetch_pkg::IDLE;
        end
      endcase
    end
  end

  // payload capture
  always_ff @(posedge clk)
  begin
    // pc taken on the upstream handshake
    if (req_valid_i && req_ready_o)
    begin
      pc_q.raw <= req_pc_i;
    end
    // word taken on a hit, stays put through DELIVER
    if ((state_q == ifetch_pkg::LOOKUP) && lookup.hit)
    begin
      inst_q <= lookup.word;
    end
  end

endmodule

`default_nettype wire

// File: rtl/l1i_array.sv
`default_nettype none

`include "ifetch_settings.svh"

module l1i_array (
  input  logic        clk,
  input  logic        rst,
  // lookup from the controller
  l1i_lookup_if.array lookup,
  // line writes from the refill unit
  l1i_fill_if.array   fill
);

  // per-line state
  logic [`L1I_LINES-1:0]     valid_q;
  logic [`L1I_TAG_W-1:0]     tag_q  [`L1I_LINES];
  logic [`IFETCH_ADDR_W-1:0] data_q [`L1I_LINES][2**`L1I_OFFSET_W];

  // decoded fields of the lookup address
  logic [`L1I_TAG_W-1:0]     look_tag;
  logic [`L1I_INDEX_W-1:0]   look_index;
  logic [`L1I_OFFSET_W-1:0]  look_offset;

  assign look_tag    = lookup.lookup_addr.f.tag;
  assign look_index  = lookup.lookup_addr.f.index;
  assign look_offset = lookup.lookup_addr.f.offset;

  // tag compare, only counts for a valid line
  assign lookup.hit  = valid_q[look_index] && (tag_q[look_index] == look_tag);

  // word select by offset
  // meaningless on a miss, controller ignores it then
  assign lookup.word = data_q[look_index][look_offset];

  // valid bits
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else if (lookup.flush_all)
    begin
      // fence.i invalidates everything
      valid_q <= '0;
    end
    else if (fill.fill_we && (fill.fill_offset == `L1I_OFFSET_W'(1)))
    begin
      // line is complete with the second word
      valid_q[fill.fill_index] <= 1'b1;
    end
  end

  // tag and data storage
  always_ff @(posedge clk)
  begin
    if (fill.fill_we)
    begin
      data_q[fill.fill_index][fill.fill_offset] <= fill.fill_word;
      // tag goes in together with the last word
      if (fill.fill_offset == `L1I_OFFSET_W'(1))
      begin
        tag_q[fill.fill_index] <= fill.fill_tag;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/l1i_refill.sv
`default_nettype none

`include "ifetch_settings.svh"

module l1i_refill (
  input  logic                      clk,
  input  logic                      rst,
  // request from the controller
  input  logic                      refill_start_i,
  input  ifetch_pkg::l1i_addr_u     refill_addr_i,
  // single-word read bus
  output logic [`IFETCH_ADDR_W-1:0] mem_araddr_o,
  output logic                      mem_arvalid_o,
  input  logic [`IFETCH_ADDR_W-1:0] mem_rdata_i,
  input  logic                      mem_rvalid_i,
  // line writes into the array
  l1i_fill_if.refill                fill
);

  // line being refilled
  logic [`L1I_TAG_W-1:0]    tag_q;
  logic [`L1I_INDEX_W-1:0]  index_q;
  // word currently requested
  logic [`L1I_OFFSET_W-1:0] offset_q;
  // read outstanding
  logic                     arvalid_q;
  // word returned this cycle
  logic                     beat;
  logic                     last_word;
  ifetch_pkg::l1i_addr_u    araddr;

  assign beat      = arvalid_q && mem_rvalid_i;
  assign last_word = (offset_q == `L1I_OFFSET_W'(1));

  // bus address built from the latched line and the word offset
  always_comb
  begin
    araddr.f.tag      = tag_q;
    araddr.f.index    = index_q;
    araddr.f.offset   = offset_q;
    araddr.f.byte_sel = 2'b00;
  end

  assign mem_araddr_o  = araddr.raw;
  assign mem_arvalid_o = arvalid_q;

  // returned word goes straight into the array
  assign fill.fill_we     = beat;
  assign fill.fill_index  = index_q;
  assign fill.fill_offset = offset_q;
  assign fill.fill_tag    = tag_q;
  assign fill.fill_word   = mem_rdata_i;
  assign fill.line_done   = beat && last_word;

  // read sequencing
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      arvalid_q <= 1'b0;
      offset_q  <= '0;
    end
    else if (refill_start_i)
    begin
      // first read, word 0 of the line
      arvalid_q <= 1'b1;
      offset_q  <= '0;
    end
    else if (beat)
    begin
      if (last_word)
      begin
        // line finished
        arvalid_q <= 1'b0;
        offset_q  <= '0;
      end
      else
      begin
        // next cycle asks for word 1
        offset_q <= offset_q + `L1I_OFFSET_W'(1);
      end
    end
  end

  // line address latched at start
  always_ff @(posedge clk)
  begin
    if (refill_start_i)
    begin
      tag_q   <= refill_addr_i.f.tag;
      index_q <= refill_addr_i.f.index;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ifetch_top.sv
`default_nettype none

`include "ifetch_settings.svh"

module ifetch_top (
  input  logic                      clk,
  input  logic                      rst,
  // upstream pc handshake
  input  logic                      req_valid_i,
  input  logic [`IFETCH_ADDR_W-1:0] req_pc_i,
  output logic                      req_ready_o,
  // downstream instruction handshake
  output logic                      inst_valid_o,
  output logic [`IFETCH_ADDR_W-1:0] inst_o,
  output logic [`IFETCH_ADDR_W-1:0] pc_o,
  input  logic                      inst_ready_i,
  // read bus
  output logic [`IFETCH_ADDR_W-1:0] mem_araddr_o,
  output logic                      mem_arvalid_o,
  input  logic [`IFETCH_ADDR_W-1:0] mem_rdata_i,
  input  logic                      mem_rvalid_i
);

  // controller to refill unit
  logic                  refill_start;
  ifetch_pkg::l1i_addr_u refill_addr;

  l1i_lookup_if lookup_bus ();
  l1i_fill_if   fill_bus ();

  // sequencing and handshakes
  ifetch_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid_i),
    .req_pc_i       (req_pc_i),
    .req_ready_o    (req_ready_o),
    .inst_valid_o   (inst_valid_o),
    .inst_o         (inst_o),
    .pc_o           (pc_o),
    .inst_ready_i   (inst_ready_i),
    .lookup         (lookup_bus.ctrl),
    .refill_start_o (refill_start),
    .refill_addr_o  (refill_addr),
    .fill           (fill_bus.ctrl)
  );

  // tags, valid bits and data
  l1i_array u_array (
    .clk    (clk),
    .rst    (rst),
    .lookup (lookup_bus.array),
    .fill   (fill_bus.array)
  );

  // two-read line refill
  l1i_refill u_refill (
    .clk            (clk),
    .rst            (rst),
    .refill_start_i (refill_start),
    .refill_addr_i  (refill_addr),
    .mem_araddr_o   (mem_araddr_o),
    .mem_arvalid_o  (mem_arvalid_o),
    .mem_rdata_i    (mem_rdata_i),
    .mem_rvalid_i   (mem_rvalid_i),
    .fill           (fill_bus.refill)
  );

endmodule

`default_nettype wire

// File: tb/ifetch_asserts.sv
`default_nettype none

`include "ifetch_settings.svh"

module ifetch_asserts (
  input logic                      clk,
  input logic                      rst,
  input logic [`IFETCH_ADDR_W-1:0] mem_araddr_i,
  input logic                      mem_arvalid_i,
  input logic                      mem_rvalid_i,
  input logic                      inst_valid_i,
  input logic                      inst_ready_i,
  input logic [`IFETCH_ADDR_W-1:0] inst_i,
  input logic [`IFETCH_ADDR_W-1:0] pc_i,
  input logic                      req_ready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // read waiting for rvalid keeps request and address
  property araddr_held;
    @(posedge clk) disable iff (rst)
      (mem_arvalid_i && !mem_rvalid_i) |=> (mem_arvalid_i && $stable(mem_araddr_i));
  endproperty

  // stalled result must not move
  property result_held;
    @(posedge clk) disable iff (rst)
      (inst_valid_i && !inst_ready_i) |=>
        (inst_valid_i && $stable(inst_i) && $stable(pc_i));
  endproperty

  // one fetch at a time
  property no_accept_while_held;
    @(posedge clk) disable iff (rst)
      !(req_ready_i && inst_valid_i);
  endproperty

  assert property (araddr_held)
    else $error("bus read address or arvalid changed before rvalid");
  assert property (result_held)
    else $error("held instruction or pc changed before the handshake");
  assert property (no_accept_while_held)
    else $error("req_ready_o high while a result is held");

endmodule

bind ifetch_top ifetch_asserts u_asserts (
  .clk           (clk),
  .rst           (rst),
  .mem_araddr_i  (mem_araddr_o),
  .mem_arvalid_i (mem_arvalid_o),
  .mem_rvalid_i  (mem_rvalid_i),
  .inst_valid_i  (inst_valid_o),
  .inst_ready_i  (inst_ready_i),
  .inst_i        (inst_o),
  .pc_i          (pc_o),
  .req_ready_i   (req_ready_o)
);

`default_nettype wire

// File: tb/ifetch_tb.sv
`default_nettype none

`include "ifetch_settings.svh"

module ifetch_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NUM_FETCHES = 2000;
  localparam int unsigned WAIT_LIMIT  = 100;
  localparam logic [31:0] PC_BASE     = 32'h0000_4000;
  localparam logic [31:0] LFSR_SEED   = 32'h8207add6;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      req_valid;
  logic [`IFETCH_ADDR_W-1:0] req_pc;
  logic                      req_ready;
  logic                      inst_valid;
  logic [`IFETCH_ADDR_W-1:0] inst_word;
  logic [`IFETCH_ADDR_W-1:0] inst_pc;
  logic                      inst_ready;
  logic [`IFETCH_ADDR_W-1:0] mem_araddr;
  logic                      mem_arvalid;
  logic [`IFETCH_ADDR_W-1:0] mem_rdata;
  logic                      mem_rvalid;

  // separate lfsr states for stimulus and bus slave
  logic [31:0] stim_lfsr;
  logic [31:0] resp_lfsr;
  // addresses of bus reads, drained after each fetch
  logic [31:0] read_q [$];
  // cache model, tag is pc[31:6]
  logic        model_valid [`L1I_LINES];
  logic [25:0] model_tag   [`L1I_LINES];

  always #2 clk = ~clk;

  ifetch_top UUT (
    .clk           (clk),
    .rst           (rst),
    .req_valid_i   (req_valid),
    .req_pc_i      (req_pc),
    .req_ready_o   (req_ready),
    .inst_valid_o  (inst_valid),
    .inst_o        (inst_word),
    .pc_o          (inst_pc),
    .inst_ready_i  (inst_ready),
    .mem_araddr_o  (mem_araddr),
    .mem_arvalid_o (mem_arvalid),
    .mem_rdata_i   (mem_rdata),
    .mem_rvalid_i  (mem_rvalid)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    if (s[0])
    begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit
  task automatic take_bits(inout logic [31:0] state, input int unsigned n,
                           output logic [31:0] bits);
    bits = '0;
    for (int unsigned i = 0; i < n; i++)
    begin
      state = galois_step(state);
      bits  = {bits[30:0], state[0]};
    end
  endtask

  // memory contents, fixed per address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [3:0] w;
    logic [3:0] mix;
    w   = addr[5:2];
    mix = w ^ {w[0], w[3:1]};
    // top tag window, about a quarter decodes as fence.i
    if ((addr[31:8] == PC_BASE[31:8]) && (addr[7:6] == 2'b11) && (mix[1:0] == 2'b00))
    begin
      return `FENCE_I_WORD;
    end
    return (addr * 32'h9e37_79b1) ^ 32'h6d2b_79f5;
  endfunction

  task automatic compare_word(input string test, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (exp == act)
    else
    begin
      $display("ERR %s expected %08h actual %08h", test, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond)
    else
    begin
      $display("%s", what);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  // bus slave, rvalid 1 to 4 cycles after the read shows up
  initial
  begin : bus_responder
    logic [31:0] bits;
    int unsigned cnt;
    logic        busy;
    resp_lfsr  = LFSR_SEED;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    busy       = 1'b0;
    cnt        = 0;
    forever
    begin
      @(posedge clk);
      #1;
      if (mem_rvalid)
      begin
        // read ended at this edge
        mem_rvalid = 1'b0;
        busy       = 1'b0;
      end
      else if (busy)
      begin
        cnt--;
        if (cnt == 0)
        begin
          mem_rvalid = 1'b1;
          mem_rdata  = mem_word(mem_araddr);
          read_q.push_back(mem_araddr);
        end
      end
      else if (mem_arvalid && !rst)
      begin
        take_bits(resp_lfsr, 2, bits);
        cnt  = bits + 1;
        busy = 1'b1;
      end
    end
  end

  initial
  begin : main
    logic [31:0] bits;
    logic [31:0] pc;
    logic [31:0] exp_word;
    logic [2:0]  idx;
    logic        exp_hit;
    logic        done;
    int unsigned tries;
    int unsigned lat;
    stim_lfsr  = LFSR_SEED;
    rst        = 1'b1;
    req_valid  = 1'b0;
    req_pc     = '0;
    inst_ready = 1'b0;
    for (int i = 0; i < `L1I_LINES; i++)
    begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int unsigned n = 0; n < NUM_FETCHES; n++)
    begin
      // 4 tags x 8 lines x 2 words, so hits, misses and evictions mix
      take_bits(stim_lfsr, 6, bits);
      pc       = PC_BASE | {24'h0, bits[5:0], 2'b00};
      idx      = pc[5:3];
      exp_word = mem_word(pc);
      exp_hit  = model_valid[idx] && (model_tag[idx] == pc[31:6]);

      // offer the pc until it is taken
      @(posedge clk);
      #1;
      req_valid = 1'b1;
      req_pc    = pc;
      tries     = 0;
      done      = 1'b0;
      while (!done)
      begin
        @(negedge clk);
        // previous result must not show up twice
        expect_true(!inst_valid, "inst_valid_o high with no fetch in flight");
        if (req_ready)
        begin
          done = 1'b1;
        end
        else
        begin
          tries++;
          if (tries > WAIT_LIMIT)
          begin
            fail_timeout("req_ready_o");
          end
          @(posedge clk);
          #1;
        end
      end

      // accepted at the coming edge, count cycles to inst_valid_o
      lat  = 0;
      done = 1'b0;
      while (!done)
      begin
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        req_pc    = '0;
        take_bits(stim_lfsr, 2, bits);
        // ready withheld a quarter of the time
        inst_ready = (bits[1:0] != 2'b00);
        @(negedge clk);
        lat++;
        if (inst_valid)
        begin
          done = 1'b1;
        end
        else
        begin
          expect_true(!req_ready, "req_ready_o high while a fetch is in flight");
          if (lat > WAIT_LIMIT)
          begin
            fail_timeout("inst_valid_o");
          end
        end
      end
      if (exp_hit)
      begin
        compare_word("hit_latency", 32'd2, 32'(lat));
      end

      // result held until inst_ready_i
      tries = 0;
      done  = 1'b0;
      while (!done)
      begin
        expect_true(inst_valid, "inst_valid_o dropped before the handshake");
        expect_true(!req_ready, "req_ready_o high while a result is held");
        compare_word("inst_word", exp_word, inst_word);
        compare_word("pc_value", pc, inst_pc);
        if (inst_ready)
        begin
          done = 1'b1;
        end
        else
        begin
          tries++;
          if (tries > WAIT_LIMIT)
          begin
            fail_timeout("inst_ready_i handshake");
          end
          @(posedge clk);
          #1;
          take_bits(stim_lfsr, 2, bits);
          inst_ready = (bits[1:0] != 2'b00);
          @(negedge clk);
        end
      end

      // bus traffic for this fetch
      if (exp_hit)
      begin
        compare_word("hit_bus_reads", 32'd0, 32'(read_q.size()));
      end
      else
      begin
        compare_word("miss_bus_reads", 32'd2, 32'(read_q.size()));
        compare_word("refill_addr_word0", {pc[31:3], 3'b000}, read_q[0]);
        compare_word("refill_addr_word1", {pc[31:3], 3'b100}, read_q[1]);
        model_valid[idx] = 1'b1;
        model_tag[idx]   = pc[31:6];
      end
      read_q.delete();

      // fence.i delivered, whole cache gone
      if (exp_word == `FENCE_I_WORD)
      begin
        for (int i = 0; i < `L1I_LINES; i++)
        begin
          model_valid[i] = 1'b0;
        end
      end
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: ifetch_top.f
+incdir+rtl
rtl/ifetch_pkg.sv
rtl/l1i_ifs.sv
rtl/ifetch_ctrl.sv
rtl/l1i_array.sv
rtl/l1i_refill.sv
rtl/ifetch_top.sv
tb/ifetch_asserts.sv
tb/ifetch_tb.sv

// File: Makefile
# Verilator flow for the instruction fetch unit
VERILATOR ?= verilator
TOP       ?= ifetch_tb
FLIST     ?= ifetch_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG) || ! grep -q "SIMULATION PASSED" $(LOG); \
	then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
